// File: verilog/eval_pkg.sv
/* Evaluator shared definitions */

package eval_pkg;

   typedef logic [3:0]          piece_t;   // Bit 3 black, bits 2..0 type
   typedef logic [255:0]        board_t;   // Square n at bits 4n+3..4n
   typedef logic [31:0]         rank_t;    // Eight squares of one rank
   typedef logic signed [15:0]  score_t;   // Material sum
   typedef logic [5:0]          phase_t;   // 0 to phase_max
   typedef logic signed [31:0]  wide_t;    // Blend intermediate
   typedef logic signed [15:0]  eval_t;    // Final evaluation

   typedef enum logic [2:0]
   {
      st_idle,
      st_ws,                               // Board register settles
      st_wait_scan,
      st_wait_latency,
      st_wait_clear                        // Result held for host
   } state_t;

   // Square codes, colour bit clear
   localparam piece_t piece_empty  = 4'd0;
   localparam piece_t piece_pawn   = 4'd1;
   localparam piece_t piece_knight = 4'd2;
   localparam piece_t piece_bishop = 4'd3;
   localparam piece_t piece_rook   = 4'd4;
   localparam piece_t piece_queen  = 4'd5;
   localparam piece_t piece_king   = 4'd6;
   localparam int     black_bit    = 3;

   // Indexed by type field, code 7 unused
   localparam score_t mg_value [8] = '{16'sd0, 16'sd82, 16'sd337, 16'sd365,
                                       16'sd477, 16'sd1025, 16'sd0, 16'sd0};
   localparam score_t eg_value [8] = '{16'sd0, 16'sd94, 16'sd281, 16'sd297,
                                       16'sd512, 16'sd936, 16'sd0, 16'sd0};

   localparam int phase_max     = 62;
   localparam int scale_shift   = 20;
   localparam int scale_mult    = (1 << scale_shift) / phase_max; // 16912, truncated
   localparam int blend_latency = 5;                            // Stages in taper_blend
   localparam int rank_count    = 8;

endpackage

// File: verilog/latency_timer.sv
/* Blend latency timer */

module latency_timer
(
   input  logic  clk,
   input  logic  reset,
   input  logic  timer_load,
   output logic  expired
);

   logic [2:0] count;   // Cycles left in blend pipeline

   always_ff @(posedge clk)
   begin
      if (reset)
         count <= 3'd0;
      else if (timer_load)
         count <= 3'(eval_pkg::blend_latency);   // Full pipeline depth
      else if (count != 3'd0)
         count <= count - 3'd1;                  // Idles at zero
   end

   // Last tick before the count hits zero, once per load
   assign expired = (count == 3'd1);

endmodule

// File: verilog/material_scan.sv
/* Rank-serial material scanner */

module material_scan
(
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  eval_pkg::board_t  board,
   output eval_pkg::score_t  mg,
   output eval_pkg::score_t  eg,
   output logic              scan_done
);

   logic [2:0]        rank_idx;   // Rank being summed
   logic              busy;       // Scan in progress
   eval_pkg::rank_t   rank;       // Current rank slice
   eval_pkg::piece_t  sq;
   eval_pkg::score_t  rank_mg;    // Signed sum of one rank
   eval_pkg::score_t  rank_eg;

   assign rank = board[rank_idx * $bits(eval_pkg::rank_t) +: $bits(eval_pkg::rank_t)];

   // White adds, black subtracts
   always_comb
   begin
      rank_mg = '0;
      rank_eg = '0;
      sq      = '0;
      for (int f = 0; f < 8; f++)
      begin
         sq = rank[f * $bits(eval_pkg::piece_t) +: $bits(eval_pkg::piece_t)];
         if (sq[eval_pkg::black_bit])
         begin
            rank_mg = rank_mg - eval_pkg::mg_value[sq[2:0]];
            rank_eg = rank_eg - eval_pkg::eg_value[sq[2:0]];
         end
         else
         begin
            rank_mg = rank_mg + eval_pkg::mg_value[sq[2:0]];
            rank_eg = rank_eg + eval_pkg::eg_value[sq[2:0]];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         rank_idx  <= 3'd0;
         scan_done <= 1'b0;
      end
      else
      begin
         scan_done <= 1'b0;                  // Single cycle pulse
         if (start)
         begin
            busy     <= 1'b1;
            rank_idx <= 3'd0;
         end
         else if (busy)
         begin
            rank_idx <= rank_idx + 3'd1;
            if (rank_idx == 3'(eval_pkg::rank_count - 1))
            begin
               busy      <= 1'b0;
               scan_done <= 1'b1;            // Sums final from here on
            end
         end
      end
   end

   // Accumulators, held after the scan
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         mg <= '0;
         eg <= '0;
      end
      else if (busy)
      begin
         mg <= mg + rank_mg;
         eg <= eg + rank_eg;
      end
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (reset)
      scan_done |=> !scan_done);

endmodule

// File: verilog/phase_count.sv
/* Game phase counter */

module phase_count
(
   input  logic              clk,
   input  logic              reset,
   input  eval_pkg::board_t  board,
   output eval_pkg::phase_t  phase
);

   logic [63:0] heavy;    // Square holds a non-pawn piece
   logic [6:0]  count;    // Up to 64 squares

   // Stage one, per-square flags
   always_ff @(posedge clk)
   begin
      if (reset)
         heavy <= '0;
      else
         for (int s = 0; s < 64; s++)
            heavy[s] <= board[s * 4 +: 4] != eval_pkg::piece_empty &&
                        board[s * 4 +: 3] != eval_pkg::piece_pawn[2:0];
   end

   always_comb
   begin
      count = '0;
      for (int s = 0; s < 64; s++)
         count = count + 7'(heavy[s]);
   end

   // Stage two, clamped population count
   always_ff @(posedge clk)
   begin
      if (reset)
         phase <= '0;
      else if (count > 7'(eval_pkg::phase_max))
         phase <= eval_pkg::phase_t'(eval_pkg::phase_max);
      else
         phase <= eval_pkg::phase_t'(count);
   end

endmodule

// File: verilog/taper_blend.sv
/* Tapered score blend pipeline */

module taper_blend
(
   input  logic              clk,
   input  logic              reset,
   input  eval_pkg::score_t  mg,
   input  eval_pkg::score_t  eg,
   input  eval_pkg::phase_t  phase,
   output eval_pkg::eval_t   eval
);

   eval_pkg::wide_t                           prod_mg;     // Stage 1
   eval_pkg::wide_t                           prod_eg;
   eval_pkg::wide_t                           sum;         // Stage 2
   logic signed [2*$bits(eval_pkg::wide_t)-1:0] scaled;    // Stage 3, needs 37 bits
   logic signed [2*$bits(eval_pkg::wide_t)-1:0] scaled_adj; // Bias for negative values
   eval_pkg::wide_t                           quot;        // Stage 4

   // Shift then rounds toward zero like a divide
   always_comb
   begin
      if (scaled[$bits(scaled) - 1])
         scaled_adj = scaled + (64'sd1 <<< eval_pkg::scale_shift) - 64'sd1;
      else
         scaled_adj = scaled;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         prod_mg <= '0;
         prod_eg <= '0;
         sum     <= '0;
         scaled  <= '0;
         quot    <= '0;
         eval    <= '0;
      end
      else
      begin
         prod_mg <= eval_pkg::wide_t'(mg) * eval_pkg::wide_t'(phase);
         prod_eg <= eval_pkg::wide_t'(eg) *
                    (eval_pkg::wide_t'(eval_pkg::phase_max) - eval_pkg::wide_t'(phase));
         sum     <= prod_mg + prod_eg;
         scaled  <= 64'(sum) * 64'(eval_pkg::scale_mult);   // Divide by 62 in fixed point
         quot    <= eval_pkg::wide_t'(scaled_adj >>> eval_pkg::scale_shift);
         eval    <= eval_pkg::eval_t'(quot);                // Low 16 bits
      end
   end

endmodule

// File: verilog/eval_fsm.sv
/* Evaluation control FSM */

module eval_fsm
(
   input  logic              clk,
   input  logic              reset,
   input  logic              board_valid,
   input  eval_pkg::board_t  board_in,
   input  logic              clear_eval,
   input  logic              scan_done,
   input  logic              expired,
   output eval_pkg::board_t  board,
   output logic              start,
   output logic              timer_load,
   output logic              eval_valid
);

   eval_pkg::state_t state;
   logic             board_valid_r;    // Previous board_valid
   logic             board_edge;       // Rising edge of board_valid

   assign board_edge = board_valid && !board_valid_r;

   // Scan kicks off once the board register is stable
   assign start      = (state == eval_pkg::st_ws);
   assign timer_load = (state == eval_pkg::st_wait_scan) && scan_done; // Cover blend depth

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= eval_pkg::st_idle;
         board_valid_r <= 1'b0;
         eval_valid    <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;   // Edge detect runs in every state
         case (state)
            eval_pkg::st_idle:
               if (board_edge)
                  state <= eval_pkg::st_ws;
            eval_pkg::st_ws:
               state <= eval_pkg::st_wait_scan;
            eval_pkg::st_wait_scan:
               if (scan_done)
                  state <= eval_pkg::st_wait_latency;
            eval_pkg::st_wait_latency:
               if (expired)
               begin
                  state      <= eval_pkg::st_wait_clear;
                  eval_valid <= 1'b1;    // Blend output now settled
               end
            eval_pkg::st_wait_clear:
               if (clear_eval)
               begin
                  state      <= eval_pkg::st_idle;
                  eval_valid <= 1'b0;
               end
            default:
            begin
               state      <= eval_pkg::st_idle;
               eval_valid <= 1'b0;
            end
         endcase
      end
   end

   // Board only captured on a new request, later changes ignored
   always_ff @(posedge clk)
   begin
      if (state == eval_pkg::st_idle && board_edge)
         board <= board_in;
   end

   // Result flag only ever raised while the result is being held
   a_valid_in_clear: assert property (@(posedge clk) disable iff (reset)
      eval_valid |-> state == eval_pkg::st_wait_clear);

endmodule

// File: verilog/evaluate_top.sv
/* Position evaluator top */

module evaluate_top
(
   input  logic              clk,
   input  logic              reset,
   input  logic              board_valid,
   input  eval_pkg::board_t  board_in,
   input  logic              clear_eval,
   output eval_pkg::eval_t   eval,
   output logic              eval_valid
);

   eval_pkg::board_t  board;        // Latched request board
   logic              start;        // Scan trigger
   logic              timer_load;
   logic              scan_done;
   logic              expired;      // Blend output settled
   eval_pkg::score_t  mg;
   eval_pkg::score_t  eg;
   eval_pkg::phase_t  phase;

   eval_fsm i_fsm
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .scan_done   (scan_done),
      .expired     (expired),
      .board       (board),
      .start       (start),
      .timer_load  (timer_load),
      .eval_valid  (eval_valid)
   );

   latency_timer i_timer
   (
      .clk         (clk),
      .reset       (reset),
      .timer_load  (timer_load),
      .expired     (expired)
   );

   material_scan i_scan
   (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .board       (board),
      .mg          (mg),
      .eg          (eg),
      .scan_done   (scan_done)
   );

   // Phase and blend run freely off the latched board
   phase_count i_phase
   (
      .clk         (clk),
      .reset       (reset),
      .board       (board),
      .phase       (phase)
   );

   taper_blend i_blend
   (
      .clk         (clk),
      .reset       (reset),
      .mg          (mg),
      .eg          (eg),
      .phase       (phase),
      .eval        (eval)
   );

endmodule

// File: testbench/tb_clock.sv
/* Testbench clock */

module tb_clock
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;   // Period 20
   end

endmodule

// File: testbench/tb_tasks.svh
/* Evaluator reference model and tests */

// Middle-game and end-game value of one piece type
function automatic longint piece_value(logic [2:0] kind, bit endgame);
   case (kind)
      3'd1:    return endgame ? 64'sd94  : 64'sd82;     // Pawn
      3'd2:    return endgame ? 64'sd281 : 64'sd337;    // Knight
      3'd3:    return endgame ? 64'sd297 : 64'sd365;    // Bishop
      3'd4:    return endgame ? 64'sd512 : 64'sd477;    // Rook
      3'd5:    return endgame ? 64'sd936 : 64'sd1025;   // Queen
      default: return 64'sd0;                           // Empty and king
   endcase
endfunction

function automatic eval_pkg::eval_t model_eval(eval_pkg::board_t b);
   eval_pkg::piece_t p;
   longint           mg;
   longint           eg;
   longint           phase;
   mg    = 0;
   eg    = 0;
   phase = 0;
   for (int s = 0; s < 64; s++)
   begin
      p = b[s * 4 +: 4];
      if (p[3])
      begin
         mg = mg - piece_value(p[2:0], 1'b0);   // Black counts against
         eg = eg - piece_value(p[2:0], 1'b1);
      end
      else
      begin
         mg = mg + piece_value(p[2:0], 1'b0);
         eg = eg + piece_value(p[2:0], 1'b1);
      end
      if (p[2:0] > 3'd1)
         phase = phase + 1;                     // Knight up to king
   end
   if (phase > 62)
      phase = 62;
   // Signed divide truncates toward zero
   return eval_pkg::eval_t'((mg * phase + eg * (62 - phase)) * 16912 / 1048576);
endfunction

function automatic eval_pkg::board_t place_piece(eval_pkg::board_t b, int sq,
                                                 eval_pkg::piece_t p);
   b[sq * 4 +: 4] = p;
   return b;
endfunction

function automatic eval_pkg::board_t start_board();
   eval_pkg::board_t b;
   logic [2:0]       back [8];
   b    = '0;
   back = '{3'd4, 3'd2, 3'd3, 3'd5, 3'd6, 3'd3, 3'd2, 3'd4};   // Files a to h
   for (int f = 0; f < 8; f++)
   begin
      b = place_piece(b, f, {1'b0, back[f]});
      b = place_piece(b, 8 + f, 4'd1);          // White pawns
      b = place_piece(b, 48 + f, 4'd9);         // Black pawns
      b = place_piece(b, 56 + f, {1'b1, back[f]});
   end
   return b;
endfunction

// Kings on e1 and e8 plus a queen on d1 or d8
function automatic eval_pkg::board_t queen_board(bit black);
   eval_pkg::board_t b;
   b = place_piece('0, 4, 4'd6);
   b = place_piece(b, 60, 4'd14);
   if (black)
      b = place_piece(b, 59, 4'd13);
   else
      b = place_piece(b, 3, 4'd5);
   return b;
endfunction

function automatic eval_pkg::board_t random_board();
   eval_pkg::board_t b;
   logic [31:0]      r;
   int               placed;
   b      = '0;
   r      = $random(seed);
   placed = 2 + int'(r % 23);                  // At most 24 pieces keeps sums in 16 bits
   for (int n = 0; n < placed; n++)
   begin
      r = $random(seed);
      b = place_piece(b, int'(r[5:0]), {r[6], 3'(1 + r[15:8] % 6)});   // Pawn to king
   end
   return b;
endfunction

task automatic compare_eval(input string name, input eval_pkg::eval_t expected,
                            input eval_pkg::eval_t actual);
   if (actual !== expected)
   begin
      mismatch_count++;
      $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
   end
endtask

task automatic compare_flag(input string name, input logic expected, input logic actual);
   if (actual !== expected)
   begin
      mismatch_count++;
      $display("mismatch %s: expected %b, actual %b", name, expected, actual);
   end
endtask

task automatic wait_for_valid(input string name, input logic level);
   int cycles;
   cycles = 0;
   while (eval_valid !== level && cycles < wait_limit)
   begin
      @(negedge clk);
      cycles++;
   end
   if (eval_valid !== level)
   begin
      timeout_count++;
      $display("%s: eval_valid did not go to %b within %0d cycles", name, level, wait_limit);
   end
endtask

task automatic request_eval(input eval_pkg::board_t b);
   @(negedge clk);
   board_in    = b;
   board_valid = 1'b1;                          // Rising edge starts a run
endtask

task automatic release_eval(input string name);
   @(negedge clk);
   clear_eval = 1'b1;
   wait_for_valid(name, 1'b0);
   clear_eval = 1'b0;
endtask

task automatic run_board(input string name, input eval_pkg::board_t b,
                         input eval_pkg::eval_t expected);
   request_eval(b);
   wait_for_valid(name, 1'b1);
   compare_eval(name, expected, eval);
   release_eval(name);
   board_valid = 1'b0;                          // Rearm edge detect
endtask

task automatic test_reset();
   compare_flag("reset", 1'b0, eval_valid);
   repeat (20)
   begin
      @(negedge clk);
      compare_flag("reset idle", 1'b0, eval_valid);
   end
endtask

task automatic test_start_position();
   run_board("start position", start_board(), 16'sd0);   // Symmetric material
endtask

task automatic test_lone_queen();
   longint q;
   q = (1025 * 3 + 936 * 59) * 16912 / 1048576;           // Phase 3
   run_board("white queen", queen_board(1'b0), eval_pkg::eval_t'(q));
   run_board("black queen", queen_board(1'b1), eval_pkg::eval_t'(-q));
endtask

task automatic test_random_boards();
   eval_pkg::board_t b;
   for (int i = 0; i < 12; i++)
   begin
      b = random_board();
      run_board($sformatf("random %0d", i), b, model_eval(b));
   end
endtask

task automatic test_handshake();
   eval_pkg::eval_t expected;
   expected = model_eval(queen_board(1'b0));
   request_eval(queen_board(1'b0));
   @(negedge clk);
   board_in = start_board();                   // Ignored while busy
   wait_for_valid("handshake", 1'b1);
   repeat (10)
   begin
      @(negedge clk);
      compare_flag("handshake hold", 1'b1, eval_valid);
      compare_eval("handshake hold", expected, eval);
   end
   @(negedge clk);
   clear_eval = 1'b1;                          // board_valid still high
   @(negedge clk);
   clear_eval = 1'b0;
   compare_flag("handshake clear", 1'b0, eval_valid);   // Drops one cycle after clear
   repeat (20)
   begin
      @(negedge clk);
      compare_flag("held board_valid", 1'b0, eval_valid);   // No new edge
   end
   board_valid = 1'b0;
endtask

// File: testbench/tb_evaluate.sv
/* Position evaluator testbench */

module tb_evaluate;

   logic              clk;
   logic              reset;
   logic              board_valid;
   eval_pkg::board_t  board_in;
   logic              clear_eval;
   eval_pkg::eval_t   eval;
   logic              eval_valid;
   int                mismatch_count;     // Wrong values seen
   int                timeout_count;      // Waits that ran out
   integer            seed;               // Random board stream
   localparam int     wait_limit = 100;   // Cycles per wait

   tb_clock i_clock
   (
      .clk (clk)
   );

   evaluate_top i_dut
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   `include "tb_tasks.svh"

   initial
   begin
      reset          = 1'b1;
      board_valid    = 1'b0;
      board_in       = '0;
      clear_eval     = 1'b0;
      mismatch_count = 0;
      timeout_count  = 0;
      seed           = 38510;
      repeat (5) @(negedge clk);           // Five reset edges
      reset = 1'b0;
      test_reset();
      test_start_position();
      test_lone_queen();
      test_random_boards();
      test_handshake();
      $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: src.f
+incdir+testbench
verilog/eval_pkg.sv
verilog/latency_timer.sv
verilog/material_scan.sv
verilog/phase_count.sv
verilog/taper_blend.sv
verilog/eval_fsm.sv
verilog/evaluate_top.sv
testbench/tb_clock.sv
testbench/tb_evaluate.sv

// File: Makefile
# Verilator build for the position evaluator

VERILATOR  = verilator
FILE_LIST  = src.f
TB_TOP     = tb_evaluate
RTL_TOP    = evaluate_top
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
PASS_MSG   = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
